// ==== Makefile ====
TOP := perip_top_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f perip_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/apb_gpio.sv ====
`timescale 1ns/1ps
`include "perip_macros.svh"

module apb_gpio (
    input  logic                     HCLK,
    input  logic                     rst_n_i,
    input  logic [`PERIP_ADDR_W-1:0] paddr_i,
    input  logic [`PERIP_DATA_W-1:0] pwdata_i,
    input  logic                     pwrite_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    output logic [`PERIP_DATA_W-1:0] prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    input  logic [`GPIO_PINS-1:0]    gpio_in_i,
    output logic [`GPIO_PINS-1:0]    gpio_in_sync_o,
    output logic [`GPIO_PINS-1:0]    gpio_out_o,
    output logic [`GPIO_PINS-1:0]    gpio_dir_o,
    output logic [`GPIO_PINS-1:0]    gpio_iof_o,
    output logic                     irq_o
);
    logic [`GPIO_PINS-1:0]    dir_q;
    logic [`GPIO_PINS-1:0]    out_q;
    logic [`GPIO_PINS-1:0]    iof_q;
    logic [`GPIO_PINS-1:0]    irq_en_q;
    logic [`GPIO_PINS-1:0]    irq_stat_q;
    logic [`GPIO_PINS-1:0]    sync1_q;
    logic [`GPIO_PINS-1:0]    sync2_q;
    logic [`GPIO_PINS-1:0]    prev_q;
    logic [`GPIO_PINS-1:0]    rise;
    logic [`GPIO_PINS-1:0]    stat_clr;
    logic [`PERIP_DATA_W-1:0] rd_data;
    logic                     access;
    logic                     hit;
    logic                     wr_en;
    apb_pkg::gpio_reg_e       reg_sel;

    assign access  = psel_i & penable_i;
    assign reg_sel = apb_pkg::gpio_reg_e'(paddr_i[7:0]);

    // Offset decode, anything off the map is an error
    always_comb begin
        hit     = (paddr_i[`PERIP_ADDR_W-1:8] == '0);
        rd_data = '0;
        case (reg_sel)
            apb_pkg::GPIO_DIR:      rd_data[`GPIO_PINS-1:0] = dir_q;
            apb_pkg::GPIO_OUT:      rd_data[`GPIO_PINS-1:0] = out_q;
            apb_pkg::GPIO_IOF:      rd_data[`GPIO_PINS-1:0] = iof_q;
            apb_pkg::GPIO_IRQ_EN:   rd_data[`GPIO_PINS-1:0] = irq_en_q;
            apb_pkg::GPIO_IRQ_STAT: rd_data[`GPIO_PINS-1:0] = irq_stat_q;
            apb_pkg::GPIO_IN: begin
                rd_data[`GPIO_PINS-1:0] = sync2_q;
                // Input register is read only
                if (pwrite_i) begin
                    hit = 1'b0;
                end
            end
            default:                hit = 1'b0;
        endcase
        if (!hit) begin
            rd_data = '0;
        end
    end

    assign wr_en     = access & pwrite_i & hit;
    assign pready_o  = access;
    assign pslverr_o = access & ~hit;
    assign prdata_o  = (access & ~pwrite_i) ? rd_data : '0;

    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            iof_q    <= '0;
            irq_en_q <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                apb_pkg::GPIO_DIR:    dir_q    <= pwdata_i[`GPIO_PINS-1:0];
                apb_pkg::GPIO_OUT:    out_q    <= pwdata_i[`GPIO_PINS-1:0];
                apb_pkg::GPIO_IOF:    iof_q    <= pwdata_i[`GPIO_PINS-1:0];
                apb_pkg::GPIO_IRQ_EN: irq_en_q <= pwdata_i[`GPIO_PINS-1:0];
                default: ;
            endcase
        end
    end

    // Two flop synchronizer plus edge history
    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise     = sync2_q & ~prev_q;
    assign stat_clr = (wr_en && reg_sel == apb_pkg::GPIO_IRQ_STAT) ?
                      pwdata_i[`GPIO_PINS-1:0] : '0;

    // New edge beats a clear in the same cycle
    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            irq_stat_q <= '0;
        end else begin
            irq_stat_q <= (irq_stat_q & ~stat_clr) | (rise & irq_en_q);
        end
    end

    assign irq_o          = |irq_stat_q;
    assign gpio_in_sync_o = sync2_q;
    assign gpio_out_o     = out_q;
    assign gpio_dir_o     = dir_q;
    assign gpio_iof_o     = iof_q;

endmodule

// ==== logic/apb_pkg.sv ====
package apb_pkg;

    // Bit position on the one-hot select vector
    typedef enum logic [1:0] {
        DEV_TIMER = 2'd0,
        DEV_GPIO0 = 2'd1,
        DEV_GPIO1 = 2'd2
    } dev_e;

    // GPIO register map
    typedef enum logic [7:0] {
        GPIO_DIR      = 8'h00,
        GPIO_OUT      = 8'h04,
        GPIO_IN       = 8'h08,
        GPIO_IOF      = 8'h0C,
        GPIO_IRQ_EN   = 8'h10,
        GPIO_IRQ_STAT = 8'h14
    } gpio_reg_e;

    // Timer register map
    typedef enum logic [7:0] {
        TMR_CTRL   = 8'h00,
        TMR_PERIOD = 8'h04,
        TMR_CMP0   = 8'h08,
        TMR_CMP1   = 8'h0C,
        TMR_CMP2   = 8'h10,
        TMR_CMP3   = 8'h14
    } tmr_reg_e;

endpackage

// ==== logic/apb_pwm_timer.sv ====
`timescale 1ns/1ps
`include "perip_macros.svh"

module apb_pwm_timer (
    input  logic                     HCLK,
    input  logic                     rst_n_i,
    input  logic [`PERIP_ADDR_W-1:0] paddr_i,
    input  logic [`PERIP_DATA_W-1:0] pwdata_i,
    input  logic                     pwrite_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    output logic [`PERIP_DATA_W-1:0] prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    output logic [`PWM_CH-1:0]       pwm_o,
    output logic [`PWM_CH-1:0]       events_o
);
    logic                     en_q;
    logic [7:0]               prescale_q;
    logic [15:0]              period_q;
    logic [15:0]              cmp_q [`PWM_CH];
    logic [7:0]               presc_cnt_q;
    logic [15:0]              cnt_q;
    logic [15:0]              cnt_next;
    logic                     tick;
    logic [`PERIP_DATA_W-1:0] rd_data;
    logic                     access;
    logic                     hit;
    logic                     wr_en;
    apb_pkg::tmr_reg_e        reg_sel;

    assign access  = psel_i & penable_i;
    assign reg_sel = apb_pkg::tmr_reg_e'(paddr_i[7:0]);

    always_comb begin
        hit     = (paddr_i[`PERIP_ADDR_W-1:8] == '0);
        rd_data = '0;
        case (reg_sel)
            apb_pkg::TMR_CTRL: begin
                rd_data[0]    = en_q;
                rd_data[15:8] = prescale_q;
            end
            apb_pkg::TMR_PERIOD: rd_data[15:0] = period_q;
            apb_pkg::TMR_CMP0:   rd_data[15:0] = cmp_q[0];
            apb_pkg::TMR_CMP1:   rd_data[15:0] = cmp_q[1];
            apb_pkg::TMR_CMP2:   rd_data[15:0] = cmp_q[2];
            apb_pkg::TMR_CMP3:   rd_data[15:0] = cmp_q[3];
            default:             hit = 1'b0;
        endcase
        if (!hit) begin
            rd_data = '0;
        end
    end

    assign wr_en     = access & pwrite_i & hit;
    assign pready_o  = access;
    assign pslverr_o = access & ~hit;
    assign prdata_o  = (access & ~pwrite_i) ? rd_data : '0;

    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q       <= 1'b0;
            prescale_q <= '0;
            period_q   <= '0;
            for (int n = 0; n < `PWM_CH; n++) begin
                cmp_q[n] <= '0;
            end
        end else if (wr_en) begin
            case (reg_sel)
                apb_pkg::TMR_CTRL: begin
                    en_q       <= pwdata_i[0];
                    prescale_q <= pwdata_i[15:8];
                end
                apb_pkg::TMR_PERIOD: period_q <= pwdata_i[15:0];
                apb_pkg::TMR_CMP0:   cmp_q[0] <= pwdata_i[15:0];
                apb_pkg::TMR_CMP1:   cmp_q[1] <= pwdata_i[15:0];
                apb_pkg::TMR_CMP2:   cmp_q[2] <= pwdata_i[15:0];
                apb_pkg::TMR_CMP3:   cmp_q[3] <= pwdata_i[15:0];
                default: ;
            endcase
        end
    end

    // One tick every prescale+1 cycles
    assign tick     = en_q && (presc_cnt_q == prescale_q);
    assign cnt_next = (cnt_q == period_q) ? 16'd0 : cnt_q + 16'd1;

    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            presc_cnt_q <= '0;
            cnt_q       <= '0;
        end else if (!en_q) begin
            presc_cnt_q <= '0;
            cnt_q       <= '0;
        end else if (tick) begin
            presc_cnt_q <= '0;
            cnt_q       <= cnt_next;
        end else begin
            presc_cnt_q <= presc_cnt_q + 8'd1;
        end
    end

    // Levels lag the counter by one edge, events land with the new count
    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pwm_o    <= '0;
            events_o <= '0;
        end else begin
            for (int n = 0; n < `PWM_CH; n++) begin
                pwm_o[n]    <= (cnt_q < cmp_q[n]);
                events_o[n] <= tick && (cnt_next == cmp_q[n]);
            end
        end
    end

endmodule

// ==== logic/gpio_pinmux.sv ====
`timescale 1ns/1ps
`include "perip_macros.svh"

module gpio_pinmux (
    input  logic [`GPIO_PINS-1:0] gpio_out_i,
    input  logic [`GPIO_PINS-1:0] gpio_dir_i,
    input  logic [`GPIO_PINS-1:0] gpio_iof_i,
    input  logic [`PWM_CH-1:0]    pwm_i,
    output logic [`GPIO_PINS-1:0] pad_out_o,
    output logic [`GPIO_PINS-1:0] pad_dir_o
);
    for (genvar p = 0; p < `GPIO_PINS; p++) begin : g_pin
        if (p >= pinmux_pkg::PWM_PIN_BASE && p < pinmux_pkg::PWM_PIN_FREE) begin : g_pwm
            pinmux_pkg::pin_func_e pin_func;

            // IOF hands the pad to its timer channel
            assign pin_func = gpio_iof_i[p] ? pinmux_pkg::PIN_PWM
                                            : pinmux_pkg::PIN_GPIO;
            assign pad_out_o[p] = (pin_func == pinmux_pkg::PIN_PWM) ?
                                  pwm_i[p - pinmux_pkg::PWM_PIN_BASE] : gpio_out_i[p];
            // Forced to drive while PWM owns it
            assign pad_dir_o[p] = (pin_func == pinmux_pkg::PIN_PWM) | gpio_dir_i[p];
        end else begin : g_gpio
            // No alternate function up here
            assign pad_out_o[p] = gpio_out_i[p];
            assign pad_dir_o[p] = gpio_dir_i[p];
        end
    end

endmodule

// ==== logic/perip_macros.svh ====
`ifndef PERIP_MACROS_SVH
`define PERIP_MACROS_SVH

// APB bus shape shared by every slave
`define PERIP_ADDR_W 12
`define PERIP_DATA_W 32

// Timer, GPIO0, GPIO1
`define PERIP_DEV_CNT 3

// Pins per GPIO block
`define GPIO_PINS 32

// PWM compare channels in the timer
`define PWM_CH 4

`endif

// ==== logic/perip_top.sv ====
`timescale 1ns/1ps
`include "perip_macros.svh"

module perip_top (
    input  logic                     HCLK,
    input  logic                     rst_n_i,
    input  logic [`PERIP_ADDR_W-1:0] paddr_i,
    input  logic [`PERIP_DATA_W-1:0] pwdata_i,
    input  logic                     pwrite_i,
    input  logic [`PERIP_DEV_CNT-1:0] psel_i,
    input  logic                     penable_i,
    output logic [`PERIP_DATA_W-1:0] prdata_o [`PERIP_DEV_CNT],
    output logic [`PERIP_DEV_CNT-1:0] pready_o,
    output logic [`PERIP_DEV_CNT-1:0] pslverr_o,

    input  logic [`GPIO_PINS-1:0]    gpio0_in_i,
    output logic [`GPIO_PINS-1:0]    gpio0_out_o,
    output logic [`GPIO_PINS-1:0]    gpio0_dir_o,
    output logic                     gpio0_irq_o,

    input  logic [`GPIO_PINS-1:0]    gpio1_in_i,
    output logic [`GPIO_PINS-1:0]    gpio1_out_o,
    output logic [`GPIO_PINS-1:0]    gpio1_dir_o,
    output logic                     gpio1_irq_o,

    output logic [`PWM_CH-1:0]       timer_events_o
);
    logic [`GPIO_PINS-1:0] gpio0_out;
    logic [`GPIO_PINS-1:0] gpio0_dir;
    logic [`GPIO_PINS-1:0] gpio0_iof;
    logic [`PWM_CH-1:0]    pwm;

    apb_pwm_timer i_timer (
        .HCLK      (HCLK),
        .rst_n_i   (rst_n_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pwrite_i  (pwrite_i),
        .psel_i    (psel_i[apb_pkg::DEV_TIMER]),
        .penable_i (penable_i),
        .prdata_o  (prdata_o[apb_pkg::DEV_TIMER]),
        .pready_o  (pready_o[apb_pkg::DEV_TIMER]),
        .pslverr_o (pslverr_o[apb_pkg::DEV_TIMER]),
        .pwm_o     (pwm),
        .events_o  (timer_events_o)
    );

    // GPIO0 pads pass through the pin mux
    apb_gpio i_gpio0 (
        .HCLK           (HCLK),
        .rst_n_i        (rst_n_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .pwrite_i       (pwrite_i),
        .psel_i         (psel_i[apb_pkg::DEV_GPIO0]),
        .penable_i      (penable_i),
        .prdata_o       (prdata_o[apb_pkg::DEV_GPIO0]),
        .pready_o       (pready_o[apb_pkg::DEV_GPIO0]),
        .pslverr_o      (pslverr_o[apb_pkg::DEV_GPIO0]),
        .gpio_in_i      (gpio0_in_i),
        .gpio_in_sync_o (),
        .gpio_out_o     (gpio0_out),
        .gpio_dir_o     (gpio0_dir),
        .gpio_iof_o     (gpio0_iof),
        .irq_o          (gpio0_irq_o)
    );

    // GPIO1 drives its pads directly
    apb_gpio i_gpio1 (
        .HCLK           (HCLK),
        .rst_n_i        (rst_n_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .pwrite_i       (pwrite_i),
        .psel_i         (psel_i[apb_pkg::DEV_GPIO1]),
        .penable_i      (penable_i),
        .prdata_o       (prdata_o[apb_pkg::DEV_GPIO1]),
        .pready_o       (pready_o[apb_pkg::DEV_GPIO1]),
        .pslverr_o      (pslverr_o[apb_pkg::DEV_GPIO1]),
        .gpio_in_i      (gpio1_in_i),
        .gpio_in_sync_o (),
        .gpio_out_o     (gpio1_out_o),
        .gpio_dir_o     (gpio1_dir_o),
        .gpio_iof_o     (),
        .irq_o          (gpio1_irq_o)
    );

    gpio_pinmux i_gpio_pinmux (
        .gpio_out_i (gpio0_out),
        .gpio_dir_i (gpio0_dir),
        .gpio_iof_i (gpio0_iof),
        .pwm_i      (pwm),
        .pad_out_o  (gpio0_out_o),
        .pad_dir_o  (gpio0_dir_o)
    );

endmodule

// ==== logic/pinmux_pkg.sv ====
`include "perip_macros.svh"

package pinmux_pkg;

    // GPIO0 pin driven by PWM channel 0, channel n sits at base plus n
    localparam int PWM_PIN_BASE = 32'd0;

    // First GPIO0 pin above the PWM block
    localparam int PWM_PIN_FREE = PWM_PIN_BASE + `PWM_CH;

    // Function currently owning a pad
    typedef enum logic {
        PIN_GPIO = 1'b0,
        PIN_PWM  = 1'b1
    } pin_func_e;

endpackage

// ==== perip_top.f ====
+incdir+logic
logic/apb_pkg.sv
logic/pinmux_pkg.sv
logic/apb_gpio.sv
logic/apb_pwm_timer.sv
logic/gpio_pinmux.sv
logic/perip_top.sv
test/perip_top_asserts.sv
test/perip_top_tb.sv

// ==== test/perip_top_asserts.sv ====
`timescale 1ns/1ps
`include "perip_macros.svh"

module perip_top_asserts (
    input logic                      HCLK,
    input logic                      rst_n_i,
    input logic [`PERIP_DEV_CNT-1:0] psel_i,
    input logic                      penable_i,
    input logic [`PERIP_DEV_CNT-1:0] pready_i,
    input logic [`GPIO_PINS-1:0]     iof_i,
    input logic [`GPIO_PINS-1:0]     pad_dir_i
);
    logic [`PWM_CH-1:0] pwm_iof;
    logic [`PWM_CH-1:0] pwm_dir;

    assign pwm_iof = iof_i[pinmux_pkg::PWM_PIN_BASE +: `PWM_CH];
    assign pwm_dir = pad_dir_i[pinmux_pkg::PWM_PIN_BASE +: `PWM_CH];

    // Ready only from a selected slave in its access phase
    ready_in_access: assert property (@(posedge HCLK) disable iff (!rst_n_i)
        (pready_i & ~(psel_i & {`PERIP_DEV_CNT{penable_i}})) == '0)
        else $error("pready raised outside an access phase");

    // Zero wait states
    single_ready: assert property (@(posedge HCLK) disable iff (!rst_n_i)
        (|pready_i) |=> !(|pready_i))
        else $error("pready held for more than one cycle of a transfer");

    pwm_pin_drives: assert property (@(posedge HCLK) disable iff (!rst_n_i)
        (pwm_iof & ~pwm_dir) == '0)
        else $error("PWM pin with IOF set is not driving its pad");

endmodule

bind perip_top perip_top_asserts i_perip_top_asserts (
    .HCLK      (HCLK),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pready_i  (pready_o),
    .iof_i     (gpio0_iof),
    .pad_dir_i (gpio0_dir_o)
);

// ==== test/perip_top_tb.sv ====
`timescale 1ns/1ps
`include "perip_macros.svh"

module perip_top_tb;
    logic                      HCLK;
    logic                      rst_n;
    logic [`PERIP_ADDR_W-1:0]  paddr;
    logic [`PERIP_DATA_W-1:0]  pwdata;
    logic                      pwrite;
    logic [`PERIP_DEV_CNT-1:0] psel;
    logic                      penable;
    logic [`PERIP_DATA_W-1:0]  prdata [`PERIP_DEV_CNT];
    logic [`PERIP_DEV_CNT-1:0] pready;
    logic [`PERIP_DEV_CNT-1:0] pslverr;
    logic [`GPIO_PINS-1:0]     gpio0_in;
    logic [`GPIO_PINS-1:0]     gpio0_out;
    logic [`GPIO_PINS-1:0]     gpio0_dir;
    logic                      gpio0_irq;
    logic [`GPIO_PINS-1:0]     gpio1_in;
    logic [`GPIO_PINS-1:0]     gpio1_out;
    logic [`GPIO_PINS-1:0]     gpio1_dir;
    logic                      gpio1_irq;
    logic [`PWM_CH-1:0]        timer_events;
    logic [16:0]               lfsr;
    int                        errors;

    perip_top i_perip_top (
        .HCLK           (HCLK),
        .rst_n_i        (rst_n),
        .paddr_i        (paddr),
        .pwdata_i       (pwdata),
        .pwrite_i       (pwrite),
        .psel_i         (psel),
        .penable_i      (penable),
        .prdata_o       (prdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr),
        .gpio0_in_i     (gpio0_in),
        .gpio0_out_o    (gpio0_out),
        .gpio0_dir_o    (gpio0_dir),
        .gpio0_irq_o    (gpio0_irq),
        .gpio1_in_i     (gpio1_in),
        .gpio1_out_o    (gpio1_out),
        .gpio1_dir_o    (gpio1_dir),
        .gpio1_irq_o    (gpio1_irq),
        .timer_events_o (timer_events)
    );

    initial begin
        HCLK = 1'b0;
        forever #20 HCLK = ~HCLK;
    end

    // Fibonacci LFSR, x^17 + x^14 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] reg_mask(input apb_pkg::dev_e dev, input logic [7:0] off);
        if (dev != apb_pkg::DEV_TIMER) begin
            return 32'hFFFF_FFFF;
        end
        // Enable in bit 0, prescale in 15:8
        if (off == apb_pkg::TMR_CTRL) begin
            return 32'h0000_FF01;
        end
        return 32'h0000_FFFF;
    endfunction

    function automatic pinmux_pkg::pin_func_e pin_func(input logic [31:0] iof, input int pin);
        if (iof[pin] && pin >= pinmux_pkg::PWM_PIN_BASE
                && pin < pinmux_pkg::PWM_PIN_BASE + `PWM_CH) begin
            return pinmux_pkg::PIN_PWM;
        end
        return pinmux_pkg::PIN_GPIO;
    endfunction

    function automatic logic [31:0] pad_out_model(input logic [31:0] out,
                                                  input logic [31:0] iof,
                                                  input logic [`PWM_CH-1:0] pwm);
        logic [31:0] pads;
        pads = out;
        for (int p = 0; p < `GPIO_PINS; p++) begin
            if (pin_func(iof, p) == pinmux_pkg::PIN_PWM) begin
                pads[p] = pwm[p - pinmux_pkg::PWM_PIN_BASE];
            end
        end
        return pads;
    endfunction

    function automatic logic [31:0] pad_dir_model(input logic [31:0] dir, input logic [31:0] iof);
        logic [31:0] pads;
        pads = dir;
        for (int p = 0; p < `GPIO_PINS; p++) begin
            if (pin_func(iof, p) == pinmux_pkg::PIN_PWM) begin
                pads[p] = 1'b1;
            end
        end
        return pads;
    endfunction

    // Counter values 0..period below cmp, each held prescale+1 cycles
    function automatic int pwm_high_cycles(input int cmp, input int prescale, input int period);
        return ((cmp < period + 1) ? cmp : period + 1) * (prescale + 1);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic apb_transfer(input apb_pkg::dev_e dev, input logic wr,
                                input logic [`PERIP_ADDR_W-1:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int n;
        @(posedge HCLK);
        #2;
        psel      = '0;
        psel[dev] = 1'b1;
        penable   = 1'b0;
        pwrite    = wr;
        paddr     = addr;
        pwdata    = wdata;
        @(posedge HCLK);
        #2;
        penable = 1'b1;
        n = 0;
        @(negedge HCLK);
        while (!pready[dev] && n < 8) begin
            @(negedge HCLK);
            n++;
        end
        if (!pready[dev]) begin
            errors++;
            $display("Timeout: slave %0d never raised ready at address %h", dev, addr);
        end
        rdata = prdata[dev];
        err   = pslverr[dev];
        @(posedge HCLK);
        #2;
        psel    = '0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input apb_pkg::dev_e dev, input logic [`PERIP_ADDR_W-1:0] addr,
                             input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(dev, 1'b1, addr, data, rdata, err);
        check("write slave error", 32'd0, 32'(err));
    endtask

    task automatic expect_read(input string name, input apb_pkg::dev_e dev,
                               input logic [`PERIP_ADDR_W-1:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(dev, 1'b0, addr, '0, rdata, err);
        check(name, exp, rdata);
        check({name, " slave error"}, 32'd0, 32'(err));
    endtask

    task automatic write_readback(input string name, input apb_pkg::dev_e dev,
                                  input logic [`PERIP_ADDR_W-1:0] addr, input logic [31:0] data);
        write_reg(dev, addr, data);
        expect_read(name, dev, addr, data & reg_mask(dev, addr[7:0]));
    endtask

    task automatic expect_error(input string name, input apb_pkg::dev_e dev, input logic wr,
                                input logic [`PERIP_ADDR_W-1:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(dev, wr, addr, rand_bits(32), rdata, err);
        check(name, 32'd1, 32'(err));
        check({name, " read data"}, 32'd0, rdata);
    endtask

    task automatic drive_pins(input int g, input logic [31:0] value);
        @(posedge HCLK);
        #2;
        if (g == 0) begin
            gpio0_in = value;
        end else begin
            gpio1_in = value;
        end
    endtask

    initial begin
        apb_pkg::dev_e      dev;
        logic [31:0]        dir_v [2];
        logic [31:0]        out_v [2];
        logic [31:0]        in_v [2];
        logic [31:0]        en_v;
        logic [31:0]        stat_v;
        logic [31:0]        clr_v;
        logic [31:0]        iof_v;
        logic [15:0]        period_v;
        logic [7:0]         presc_v;
        logic [15:0]        cmp_v [`PWM_CH];
        logic [`PWM_CH-1:0] idle_pwm;
        int                 high_cnt [`PWM_CH];
        int                 evt_cnt [`PWM_CH];
        int                 len;

        lfsr     = 17'd77485;
        errors   = 0;
        rst_n    = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        pwrite   = 1'b0;
        psel     = '0;
        penable  = 1'b0;
        gpio0_in = '0;
        gpio1_in = '0;
        repeat (4) @(posedge HCLK);
        #2;
        rst_n = 1'b1;

        check("reset events", 32'd0, 32'(timer_events));
        check("reset gpio0 dir", 32'd0, gpio0_dir);
        check("reset gpio1 dir", 32'd0, gpio1_dir);
        check("reset irqs", 32'd0, 32'({gpio1_irq, gpio0_irq}));

        // Register access with IOF clear
        for (int g = 0; g < 2; g++) begin
            dev      = (g == 0) ? apb_pkg::DEV_GPIO0 : apb_pkg::DEV_GPIO1;
            dir_v[g] = rand_bits(32);
            out_v[g] = rand_bits(32);
            write_readback("gpio dir", dev, apb_pkg::GPIO_DIR, dir_v[g]);
            write_readback("gpio out", dev, apb_pkg::GPIO_OUT, out_v[g]);
            write_readback("gpio irq en", dev, apb_pkg::GPIO_IRQ_EN, rand_bits(32));
        end
        check("gpio0 pad out", pad_out_model(out_v[0], '0, '0), gpio0_out);
        check("gpio0 pad dir", pad_dir_model(dir_v[0], '0), gpio0_dir);
        check("gpio1 pad out", out_v[1], gpio1_out);
        check("gpio1 pad dir", dir_v[1], gpio1_dir);
        write_readback("timer period", apb_pkg::DEV_TIMER, apb_pkg::TMR_PERIOD, rand_bits(32));
        for (int n = 0; n < `PWM_CH; n++) begin
            write_readback("timer cmp", apb_pkg::DEV_TIMER, 12'(apb_pkg::TMR_CMP0 + 4 * n),
                           rand_bits(32));
        end

        // Input synchronizer
        in_v[0] = rand_bits(32);
        in_v[1] = rand_bits(32);
        drive_pins(0, in_v[0]);
        drive_pins(1, in_v[1]);
        repeat (3) @(posedge HCLK);
        expect_read("gpio0 in", apb_pkg::DEV_GPIO0, apb_pkg::GPIO_IN, in_v[0]);
        expect_read("gpio1 in", apb_pkg::DEV_GPIO1, apb_pkg::GPIO_IN, in_v[1]);

        // Interrupt set, partial clear, full clear
        for (int g = 0; g < 2; g++) begin
            dev = (g == 0) ? apb_pkg::DEV_GPIO0 : apb_pkg::DEV_GPIO1;
            drive_pins(g, '0);
            repeat (3) @(posedge HCLK);
            en_v = rand_bits(32);
            write_readback("irq en", dev, apb_pkg::GPIO_IRQ_EN, en_v);
            write_reg(dev, apb_pkg::GPIO_IRQ_STAT, '1);
            expect_read("irq stat cleared", dev, apb_pkg::GPIO_IRQ_STAT, '0);
            check("irq idle", 32'd0, 32'((g == 0) ? gpio0_irq : gpio1_irq));
            in_v[g] = rand_bits(32);
            drive_pins(g, in_v[g]);
            repeat (4) @(posedge HCLK);
            stat_v = in_v[g] & en_v;
            expect_read("irq stat set", dev, apb_pkg::GPIO_IRQ_STAT, stat_v);
            check("irq raised", 32'(|stat_v), 32'((g == 0) ? gpio0_irq : gpio1_irq));
            clr_v = rand_bits(32);
            write_reg(dev, apb_pkg::GPIO_IRQ_STAT, clr_v);
            stat_v = stat_v & ~clr_v;
            expect_read("irq stat partial", dev, apb_pkg::GPIO_IRQ_STAT, stat_v);
            check("irq partial", 32'(|stat_v), 32'((g == 0) ? gpio0_irq : gpio1_irq));
            write_reg(dev, apb_pkg::GPIO_IRQ_STAT, '1);
            check("irq cleared", 32'd0, 32'((g == 0) ? gpio0_irq : gpio1_irq));
        end

        // Pin mux with the timer stopped, counter held at 0
        presc_v  = 8'(rand_bits(2));
        period_v = 16'(4 + rand_bits(3));
        write_readback("timer period", apb_pkg::DEV_TIMER, apb_pkg::TMR_PERIOD, 32'(period_v));
        for (int n = 0; n < `PWM_CH; n++) begin
            cmp_v[n]    = 16'(rand_bits(4));
            idle_pwm[n] = (cmp_v[n] != 16'd0);
            write_readback("timer cmp", apb_pkg::DEV_TIMER, 12'(apb_pkg::TMR_CMP0 + 4 * n),
                           32'(cmp_v[n]));
        end
        iof_v = (rand_bits(28) << 4) | 32'hF;
        write_readback("gpio0 iof", apb_pkg::DEV_GPIO0, apb_pkg::GPIO_IOF, iof_v);
        check("mux pad out", pad_out_model(out_v[0], iof_v, idle_pwm), gpio0_out);
        check("mux pad dir", pad_dir_model(dir_v[0], iof_v), gpio0_dir);

        // PWM duty over one full period
        write_readback("timer ctrl", apb_pkg::DEV_TIMER, apb_pkg::TMR_CTRL,
                       {16'h0, presc_v, 8'h01});
        repeat (3) @(posedge HCLK);
        len = (int'(period_v) + 1) * (int'(presc_v) + 1);
        for (int n = 0; n < `PWM_CH; n++) begin
            high_cnt[n] = 0;
            evt_cnt[n]  = 0;
        end
        repeat (len) begin
            @(negedge HCLK);
            for (int n = 0; n < `PWM_CH; n++) begin
                high_cnt[n] += int'(gpio0_out[pinmux_pkg::PWM_PIN_BASE + n]);
                evt_cnt[n]  += int'(timer_events[n]);
            end
            check("pwm pad dir", pad_dir_model(dir_v[0], iof_v), gpio0_dir);
        end
        for (int n = 0; n < `PWM_CH; n++) begin
            check("pwm high cycles", pwm_high_cycles(cmp_v[n], presc_v, period_v), high_cnt[n]);
            check("pwm events", (cmp_v[n] <= period_v) ? 32'd1 : 32'd0, evt_cnt[n]);
        end
        check("mux upper pins", pad_out_model(out_v[0], iof_v, '0) & ~32'hF,
              gpio0_out & ~32'hF);

        // Slave errors leave the registers alone
        expect_error("gpio0 unmapped read", apb_pkg::DEV_GPIO0, 1'b0, 12'h018);
        expect_error("gpio1 unmapped write", apb_pkg::DEV_GPIO1, 1'b1, 12'h01C);
        expect_error("gpio0 in write", apb_pkg::DEV_GPIO0, 1'b1, apb_pkg::GPIO_IN);
        expect_error("timer high address write", apb_pkg::DEV_TIMER, 1'b1, 12'h104);
        expect_error("gpio1 high address write", apb_pkg::DEV_GPIO1, 1'b1, 12'h200);
        expect_read("gpio0 dir kept", apb_pkg::DEV_GPIO0, apb_pkg::GPIO_DIR, dir_v[0]);
        expect_read("gpio1 dir kept", apb_pkg::DEV_GPIO1, apb_pkg::GPIO_DIR, dir_v[1]);
        expect_read("gpio0 in kept", apb_pkg::DEV_GPIO0, apb_pkg::GPIO_IN, in_v[0]);
        expect_read("timer period kept", apb_pkg::DEV_TIMER, apb_pkg::TMR_PERIOD, 32'(period_v));

        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
